// ==== src/split_defines.svh ====
`ifndef SPLIT_DEFINES_SVH
`define SPLIT_DEFINES_SVH

// ########################################
// stream split configuration
// ########################################

// number of fields, one output port each
`define SPLIT_NUM 4

// field widths, all non-zero
`define SPLIT_DATA0_W 8
`define SPLIT_DATA1_W 16
`define SPLIT_DATA2_W 4
`define SPLIT_DATA3_W 12

// 1 = skid register on the input, 0 = pass-through
`define SPLIT_S_REGS 1

`endif

// ==== src/split_pkg.sv ====
`include "split_defines.svh"

package split_pkg;

    typedef logic [`SPLIT_DATA0_W-1:0] field0_t;
    typedef logic [`SPLIT_DATA1_W-1:0] field1_t;
    typedef logic [`SPLIT_DATA2_W-1:0] field2_t;
    typedef logic [`SPLIT_DATA3_W-1:0] field3_t;

    // f0 sits in the low bits
    typedef struct packed {
        field3_t f3;
        field2_t f2;
        field1_t f1;
        field0_t f0;
    } beat_t;

    typedef logic [`SPLIT_NUM-1:0] port_mask_t;

    function automatic int field_width(int idx);
        case (idx)
            0: return $bits(field0_t);
            1: return $bits(field1_t);
            2: return $bits(field2_t);
            3: return $bits(field3_t);
            default: return 0;
        endcase
    endfunction

    // bit position of field idx inside beat_t
    function automatic int field_offset(int idx);
        int off;
        off = 0;
        for (int k = 0; k < idx; k++) begin
            off += field_width(k);
        end
        return off;
    endfunction

endpackage

// ==== src/split_input_stage.sv ====
`timescale 1ns/1ps
`include "split_defines.svh"

module split_input_stage
    import split_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cke,

    input  field0_t s_data0,
    input  field1_t s_data1,
    input  field2_t s_data2,
    input  field3_t s_data3,
    input  logic    s_valid,
    output logic    s_ready,

    output beat_t   beat,
    output logic    beat_valid,
    input  logic    beat_pop
);

    beat_t s_beat;

    assign s_beat.f0 = s_data0;
    assign s_beat.f1 = s_data1;
    assign s_beat.f2 = s_data2;
    assign s_beat.f3 = s_data3;

    generate
        if (`SPLIT_S_REGS != 0) begin : g_regs

            // ########################################
            // skid register, s_ready from a flop
            // ########################################

            beat_t main_q;
            beat_t skid_q;
            logic  main_valid;
            logic  skid_valid;
            logic  in_fire;
            logic  main_free;
            logic  to_skid;

            assign in_fire   = s_valid && !skid_valid;
            assign main_free = !main_valid || beat_pop;    // empty or leaving now
            assign to_skid   = in_fire && !main_free;      // main busy, park it

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (cke) begin
                    if (main_free) begin
                        main_valid <= skid_valid || in_fire;
                    end
                    if (to_skid) begin
                        skid_valid <= 1'b1;
                    end else if (main_free) begin
                        skid_valid <= 1'b0;   // drained into main
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (cke) begin
                    if (main_free) begin
                        main_q <= skid_valid ? skid_q : s_beat;
                    end
                    if (to_skid) begin
                        skid_q <= s_beat;
                    end
                end
            end

            assign s_ready    = !skid_valid;
            assign beat       = main_q;
            assign beat_valid = main_valid;

        end else begin : g_pass

            // no storage, accept only when all ports take it
            assign s_ready    = beat_pop;
            assign beat       = s_beat;
            assign beat_valid = s_valid;

        end
    endgenerate

endmodule

// ==== src/split_port.sv ====
`timescale 1ns/1ps

module split_port #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cke,

    // from the tracker
    input  logic     offer,
    output logic     take,

    // field of the current beat
    input  payload_t data,

    // output channel
    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    logic slot_free;

    // ########################################
    // load decision
    // ########################################

    assign slot_free = !m_valid || m_ready;       // empty or draining this cycle
    assign take      = cke && offer && slot_free;

    // ########################################
    // output register
    // ########################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (cke) begin
            if (take) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;                  // sent, nothing new
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data <= data;
        end
    end

endmodule

// ==== src/split_tracker.sv ====
`timescale 1ns/1ps
`include "split_defines.svh"

module split_tracker
    import split_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cke,

    input  logic       beat_valid,
    output port_mask_t offer,
    input  port_mask_t take,
    output logic       beat_pop
);

    port_mask_t taken_q;
    port_mask_t covered;

    // ########################################
    // offer and release
    // ########################################

    assign offer   = {`SPLIT_NUM{beat_valid}} & ~taken_q;   // only ports still owed
    assign covered = taken_q | take;

    // every port done, either earlier or right now
    assign beat_pop = cke && beat_valid && (&covered);

    // ########################################
    // taken flags
    // ########################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taken_q <= '0;
        end else if (cke) begin
            if (beat_pop) begin
                taken_q <= '0;        // next beat starts fresh
            end else begin
                taken_q <= covered;
            end
        end
    end

endmodule

// ==== src/split_pack_top.sv ====
`timescale 1ns/1ps
`include "split_defines.svh"

module split_pack_top
    import split_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cke,

    input  field0_t s_data0,
    input  field1_t s_data1,
    input  field2_t s_data2,
    input  field3_t s_data3,
    input  logic    s_valid,
    output logic    s_ready,

    output field0_t m0_data,
    output logic    m0_valid,
    input  logic    m0_ready,

    output field1_t m1_data,
    output logic    m1_valid,
    input  logic    m1_ready,

    output field2_t m2_data,
    output logic    m2_valid,
    input  logic    m2_ready,

    output field3_t m3_data,
    output logic    m3_valid,
    input  logic    m3_ready
);

    beat_t      beat;
    logic       beat_valid;
    logic       beat_pop;
    port_mask_t offer;
    port_mask_t take;

    beat_t      m_beat;                // output fields, same layout as beat
    port_mask_t m_valid;
    port_mask_t m_ready;

    assign m0_data = m_beat.f0;
    assign m1_data = m_beat.f1;
    assign m2_data = m_beat.f2;
    assign m3_data = m_beat.f3;

    assign {m3_valid, m2_valid, m1_valid, m0_valid} = m_valid;
    assign m_ready = {m3_ready, m2_ready, m1_ready, m0_ready};

    split_input_stage split_input_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .s_data0    (s_data0),
        .s_data1    (s_data1),
        .s_data2    (s_data2),
        .s_data3    (s_data3),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_pop   (beat_pop)
    );

    // ########################################
    // one output slice per field
    // ########################################

    for (genvar i = 0; i < `SPLIT_NUM; i++) begin : g_port
        localparam int W   = field_width(i);
        localparam int OFF = field_offset(i);

        split_port #(
            .payload_t (logic [W-1:0])
        ) split_port_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .cke     (cke),
            .offer   (offer[i]),
            .take    (take[i]),
            .data    (beat[OFF +: W]),
            .m_data  (m_beat[OFF +: W]),
            .m_valid (m_valid[i]),
            .m_ready (m_ready[i])
        );
    end

    split_tracker split_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .beat_valid (beat_valid),
        .offer      (offer),
        .take       (take),
        .beat_pop   (beat_pop)
    );

endmodule

// ==== verif/split_properties.sv ====
`timescale 1ns/1ps
`include "split_defines.svh"

module split_properties #(
    parameter int W = 1,
    parameter int N = 1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cke,
    input  logic         valid,
    input  logic         ready,
    input  logic [W-1:0] data,
    input  logic [N-1:0] offer,
    input  logic [N-1:0] take,
    input  logic         beat_pop
);

    logic [7:0] takes_q;    // takes seen for the current beat

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            takes_q <= '0;
        end else if (cke) begin
            if (beat_pop) begin
                takes_q <= '0;
            end else begin
                takes_q <= takes_q + 8'($countones(take));
            end
        end
    end

    // ########################################
    // handshake and tracker rules
    // ########################################

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !(ready && cke) |=> valid && $stable(data))    // no transfer, no change
        else $error("valid dropped or data changed without a transfer");

    a_take_offer: assert property (@(posedge clk) disable iff (!rst_n)
        (take & ~offer) == '0)
        else $error("take raised without an offer");

    // each port takes a beat exactly once before it is released
    a_pop_cover: assert property (@(posedge clk) disable iff (!rst_n)
        beat_pop |-> (takes_q + 8'($countones(take))) == 8'(N))
        else $error("beat released before every port took it exactly once");

endmodule

bind split_port split_properties #(.W($bits(m_data)), .N(1)) split_port_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .cke      (cke),
    .valid    (m_valid),
    .ready    (m_ready),
    .data     (m_data),
    .offer    (1'b0),
    .take     (1'b0),
    .beat_pop (1'b0)
);

bind split_tracker split_properties #(.W(1), .N(`SPLIT_NUM)) split_tracker_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .cke      (cke),
    .valid    (beat_valid),
    .ready    (beat_pop),
    .data     (1'b0),
    .offer    (offer),
    .take     (take),
    .beat_pop (beat_pop)
);

// ==== verif/split_tb.sv ====
`timescale 1ns/1ps
`include "split_defines.svh"

module split_tb
    import split_pkg::*;
();

    logic    clk;
    logic    rst_n;
    logic    cke;
    field0_t s_data0;
    field1_t s_data1;
    field2_t s_data2;
    field3_t s_data3;
    logic    s_valid;
    logic    s_ready;
    field0_t m0_data;
    field1_t m1_data;
    field2_t m2_data;
    field3_t m3_data;
    logic    m0_valid, m1_valid, m2_valid, m3_valid;
    logic    m0_ready, m1_ready, m2_ready, m3_ready;

    logic [31:0] lfsr_state;
    logic        s_fire;                        // input transfer at the coming edge
    logic [15:0] exp_q [`SPLIT_NUM][$];
    int          in_count;
    int          out_count [`SPLIT_NUM];
    int          checks, errors, tests, failed_tests, test_errors;
    string       test_name;

    wire [`SPLIT_NUM-1:0]    m_valid_all = {m3_valid, m2_valid, m1_valid, m0_valid};
    wire [$bits(beat_t)-1:0] m_data_all  = {m3_data, m2_data, m1_data, m0_data};

    split_pack_top split_pack_top_inst (
        .clk (clk), .rst_n (rst_n), .cke (cke),
        .s_data0 (s_data0), .s_data1 (s_data1), .s_data2 (s_data2), .s_data3 (s_data3),
        .s_valid (s_valid), .s_ready (s_ready),
        .m0_data (m0_data), .m0_valid (m0_valid), .m0_ready (m0_ready),
        .m1_data (m1_data), .m1_valid (m1_valid), .m1_ready (m1_ready),
        .m2_data (m2_data), .m2_valid (m2_valid), .m2_ready (m2_ready),
        .m3_data (m3_data), .m3_valid (m3_valid), .m3_ready (m3_ready)
    );

    always #2 clk = ~clk;

    // ########################################
    // helpers
    // ########################################

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          b;
        r = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error in %s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    function automatic bit queues_empty();
        for (int i = 0; i < `SPLIT_NUM; i++) begin
            if (exp_q[i].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic accept_output(input int idx, input logic [15:0] value);
        logic [15:0] expected;
        out_count[idx]++;
        if (exp_q[idx].size() == 0) begin
            report_failure($sformatf("port%0d sent a beat that was never accepted", idx));
        end else begin
            expected = exp_q[idx].pop_front();
            check_value($sformatf("port%0d data", idx), 64'(expected), 64'(value));
        end
    endtask

    // model side, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        s_fire = rst_n && cke && s_valid && s_ready;
        if (s_fire) begin
            exp_q[0].push_back(16'(s_data0));
            exp_q[1].push_back(16'(s_data1));
            exp_q[2].push_back(16'(s_data2));
            exp_q[3].push_back(16'(s_data3));
            in_count++;
        end
        if (rst_n && cke) begin
            if (m0_valid && m0_ready) accept_output(0, 16'(m0_data));
            if (m1_valid && m1_ready) accept_output(1, 16'(m1_data));
            if (m2_valid && m2_ready) accept_output(2, 16'(m2_data));
            if (m3_valid && m3_ready) accept_output(3, 16'(m3_data));
        end
    end

    // mode 0 random valid, 1 always valid, 2 stop
    task automatic drive_input(input int mode);
        if (!(s_valid && !s_fire)) begin        // pending beat stays put
            case (mode)
                0: s_valid = (random_bits(2) != 0);
                1: s_valid = 1'b1;
                default: s_valid = 1'b0;
            endcase
            if (s_valid) begin
                s_data0 = field0_t'(random_bits(`SPLIT_DATA0_W));
                s_data1 = field1_t'(random_bits(`SPLIT_DATA1_W));
                s_data2 = field2_t'(random_bits(`SPLIT_DATA2_W));
                s_data3 = field3_t'(random_bits(`SPLIT_DATA3_W));
            end
        end
    endtask

    task automatic set_ready(input logic [3:0] r);
        {m3_ready, m2_ready, m1_ready, m0_ready} = r;
    endtask

    task automatic drive_ready(input bit random_mode);
        if (random_mode) begin
            set_ready({random_bits(1) != 0, random_bits(1) != 0,
                       random_bits(1) != 0, random_bits(1) != 0});
        end else begin
            set_ready(4'hf);
        end
    endtask

    task automatic run_traffic(input int cycles, input int in_mode, input bit ready_random,
                               input bit check_full);
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
            #1;
            drive_input(in_mode);
            drive_ready(ready_random);
            if (check_full) begin
                @(negedge clk);
                if (k >= 3) begin                   // pipeline full by now
                    check_value("all outputs valid", 64'hf, 64'(m_valid_all));
                    check_value("s_ready", 64'h1, 64'(s_ready));
                end
            end
        end
    endtask

    task automatic drain(input int limit);
        int k;
        for (k = 0; k < limit; k++) begin
            @(posedge clk);
            #1;
            if (!s_valid && queues_empty()) break;
            drive_input(2);
            set_ready(4'hf);
        end
        if (k == limit) report_failure("drain timed out with beats still pending");
        for (int i = 0; i < `SPLIT_NUM; i++) begin
            check_value($sformatf("port%0d beats left", i), 64'h0, 64'(exp_q[i].size()));
        end
    endtask

    // ########################################
    // tests
    // ########################################

    initial begin
        int          k;
        int          in_before;
        int          out_before [`SPLIT_NUM];
        logic [39:0] snap_data;
        logic [3:0]  snap_valid;
        logic        snap_ready;

        clk = 1'b0;
        rst_n = 1'b0;
        cke = 1'b1;
        s_valid = 1'b0;
        s_data0 = '0;
        s_data1 = '0;
        s_data2 = '0;
        s_data3 = '0;
        set_ready(4'hf);
        s_fire = 1'b0;
        lfsr_state = 32'h2540a960;
        in_count = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        for (int i = 0; i < `SPLIT_NUM; i++) out_count[i] = 0;

        start_test("reset");
        repeat (10) begin
            @(posedge clk);
            #1;
            check_value("valid in reset", 64'h0, 64'(m_valid_all));
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("valid after reset", 64'h0, 64'(m_valid_all));
        check_value("s_ready after reset", 64'(`SPLIT_S_REGS != 0), 64'(s_ready));
        end_test();

        start_test("routing");
        run_traffic(200, 0, 1'b0, 1'b0);
        drain(100);
        end_test();

        start_test("backpressure");
        run_traffic(400, 0, 1'b1, 1'b0);
        set_ready(4'h0);
        for (k = 0; k < 20; k++) begin
            @(posedge clk);
            #1;
            drive_input(1);
            @(negedge clk);
            if (!s_ready) break;
        end
        if (k == 20) report_failure("s_ready stayed high with every output stalled");
        drain(100);
        end_test();

        start_test("throughput");
        in_before = in_count;
        for (int i = 0; i < `SPLIT_NUM; i++) out_before[i] = out_count[i];
        run_traffic(100, 1, 1'b0, 1'b1);
        drain(100);
        check_value("input beats", 64'd100, 64'(in_count - in_before));
        for (int i = 0; i < `SPLIT_NUM; i++) begin
            check_value($sformatf("port%0d beats", i), 64'(in_count - in_before),
                        64'(out_count[i] - out_before[i]));
        end
        end_test();

        start_test("clock_enable");
        run_traffic(60, 0, 1'b1, 1'b0);
        @(posedge clk);
        #1;
        cke = 1'b0;
        snap_data = m_data_all;
        snap_valid = m_valid_all;
        snap_ready = s_ready;
        repeat (8) begin
            @(posedge clk);
            #1;
            drive_input(0);
            drive_ready(1'b1);
            @(negedge clk);
            check_value("held data", 64'(snap_data), 64'(m_data_all));
            check_value("held valid", 64'(snap_valid), 64'(m_valid_all));
            check_value("held s_ready", 64'(snap_ready), 64'(s_ready));
        end
        @(posedge clk);
        #1;
        cke = 1'b1;
        run_traffic(60, 0, 1'b1, 1'b0);
        drain(100);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/split_pkg.sv
src/split_input_stage.sv
src/split_port.sv
src/split_tracker.sv
src/split_pack_top.sv
verif/split_properties.sv
verif/split_tb.sv

// ==== Makefile ====
# Verilator flow for the stream splitter

TOP             ?= split_tb
FILELIST        ?= src.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only --timing
SEED_ARGS       ?= +verilator+seed+1
PASS_TEXT       := sim passed

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
